/* Makefile */
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_mem_subsys
FILELIST ?= src.f

BUILD = obj_dir
SIM   = $(BUILD)/V$(TOP)
LOG   = sim.log
SRCS  = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* sim/offchip_mem_model.sv */
// behavioral off-chip line memory for the testbench, credit return and in-order read responses
`timescale 1ns/10ps

module offchip_mem_model #(
    parameter logic [31:0] fill_key = 32'h0
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       mem_req_valid,
    input  logic                       mem_req_write,
    input  logic [mem_pkg::addr_w-1:0] mem_req_addr,
    input  logic [mem_pkg::line_w-1:0] mem_req_wdata,
    output bit                         mem_req_credit,
    output bit                         mem_resp_valid,
    output bit   [mem_pkg::line_w-1:0] mem_resp_data,
    output bit                         fault,
    output bit                         idle,
    output int                         read_cnt,
    output int                         write_cnt
);

    localparam int mem_words = 8192;

    logic [31:0]                mem [mem_words];
    logic [mem_pkg::line_w-1:0] rd_q [$];
    logic [10:0]                line_idx;
    logic [31:0]                rng;
    int                         credits;
    int                         owed;
    int                         credit_wait;
    int                         resp_wait;

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    assign line_idx = mem_req_addr[14:4];

    always @(posedge clk) begin
        mem_req_credit <= 1'b0;
        mem_resp_valid <= 1'b0;
        if (!rst) begin
            // every word holds its own byte address xor the key
            for (int i = 0; i < mem_words; i++) begin
                mem[i[12:0]] = {i[29:0], 2'b00} ^ fill_key;
            end
            rd_q.delete();
            rng         = 32'd2957;
            credits     = bus_pkg::req_credits;
            owed        = 0;
            credit_wait = 0;
            resp_wait   = 1;
            read_cnt    <= 0;
            write_cnt   <= 0;
        end else begin
            if (mem_req_valid) begin
                if (credits == 0) begin
                    $display("offchip model: request issued while no credit was left");
                    fault <= 1'b1;
                end
                credits = credits - 1;
                owed    = owed + 1;
                if (mem_req_write) begin
                    // written before any later request is served
                    for (int k = 0; k < 4; k++) begin
                        mem[{line_idx, k[1:0]}] = mem_req_wdata[k*32 +: 32];
                    end
                    write_cnt <= write_cnt + 1;
                end else begin
                    if (rd_q.size() == bus_pkg::resp_depth) begin
                        $display("offchip model: too many reads in flight to answer in order");
                        fault <= 1'b1;
                    end
                    rd_q.push_back({mem[{line_idx, 2'd3}], mem[{line_idx, 2'd2}],
                                    mem[{line_idx, 2'd1}], mem[{line_idx, 2'd0}]});
                    read_cnt <= read_cnt + 1;
                end
            end
            // one credit pulse per cycle at most
            if (owed > 0 && credit_wait == 0) begin
                mem_req_credit <= 1'b1;
                owed        = owed - 1;
                credits     = credits + 1;
                rng         = xorshift(rng);
                credit_wait = int'(rng & 32'd3);
            end else if (credit_wait > 0) begin
                credit_wait = credit_wait - 1;
            end
            if (rd_q.size() > 0 && resp_wait == 0) begin
                mem_resp_valid <= 1'b1;
                mem_resp_data  <= rd_q.pop_front();
                rng       = xorshift(rng);
                resp_wait = int'(rng & 32'd7);
            end else if (resp_wait > 0) begin
                resp_wait = resp_wait - 1;
            end
        end
        idle <= (owed == 0) && (rd_q.size() == 0);
    end

endmodule

/* sim/tb_mem_subsys.sv */
// table-driven testbench checking memory subsystem accesses against a shadow memory
`timescale 1ns/10ps

module tb_mem_subsys;

    localparam logic [31:0] fill_key       = 32'h5a3c_96e1;
    localparam int          timeout_cycles = 200;
    localparam logic [1:0]  k_inst         = 2'd0;
    localparam logic [1:0]  k_read         = 2'd1;
    localparam logic [1:0]  k_write        = 2'd2;

    // one CPU access where par adds a fetch in the same cycle
    typedef struct packed {
        logic [1:0]  kind;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        par;
        logic [31:0] par_addr;
        logic        no_fill;
    } row_t;

    localparam int   n_rows = 19;
    localparam row_t rows [n_rows] = '{
        // line fill, then hits in the same line
        '{k_inst,  32'h0000_0200, 32'h0,         1'b0, 32'h0,         1'b0},
        '{k_inst,  32'h0000_0204, 32'h0,         1'b0, 32'h0,         1'b1},
        '{k_inst,  32'h0000_0200, 32'h0,         1'b0, 32'h0,         1'b1},
        // write allocate and read back
        '{k_write, 32'h0000_1040, 32'hdead_beef, 1'b0, 32'h0,         1'b0},
        '{k_read,  32'h0000_1040, 32'h0,         1'b0, 32'h0,         1'b1},
        '{k_read,  32'h0000_1044, 32'h0,         1'b0, 32'h0,         1'b1},
        '{k_write, 32'h0000_1048, 32'h1234_5678, 1'b0, 32'h0,         1'b1},
        '{k_read,  32'h0000_1048, 32'h0,         1'b0, 32'h0,         1'b1},
        '{k_read,  32'h0000_104c, 32'h0,         1'b0, 32'h0,         1'b1},
        // index 4 again under other tags
        '{k_read,  32'h0000_1140, 32'h0,         1'b0, 32'h0,         1'b0},
        '{k_read,  32'h0000_1040, 32'h0,         1'b0, 32'h0,         1'b0},
        '{k_read,  32'h0000_1048, 32'h0,         1'b0, 32'h0,         1'b1},
        '{k_write, 32'h0000_1144, 32'h0bad_f00d, 1'b0, 32'h0,         1'b0},
        '{k_read,  32'h0000_1040, 32'h0,         1'b0, 32'h0,         1'b0},
        '{k_read,  32'h0000_1144, 32'h0,         1'b0, 32'h0,         1'b0},
        // both caches miss together
        '{k_write, 32'h0000_3080, 32'hcafe_0001, 1'b1, 32'h0000_0700, 1'b0},
        '{k_read,  32'h0000_4080, 32'h0,         1'b1, 32'h0000_0800, 1'b0},
        // lone fetch miss so the data side wins the next tie
        '{k_inst,  32'h0000_0a00, 32'h0,         1'b0, 32'h0,         1'b0},
        '{k_read,  32'h0000_3080, 32'h0,         1'b1, 32'h0000_0900, 1'b0}
    };

    logic                       clk;
    logic                       rst;
    logic [mem_pkg::addr_w-1:0] inst_addr;
    logic                       inst_read;
    logic [mem_pkg::word_w-1:0] inst_rdata;
    logic                       inst_ready;
    logic [mem_pkg::addr_w-1:0] data_addr;
    logic                       data_read;
    logic                       data_write;
    logic [mem_pkg::word_w-1:0] data_wdata;
    logic [mem_pkg::word_w-1:0] data_rdata;
    logic                       data_ready;
    logic                       mem_req_valid;
    logic                       mem_req_write;
    logic [mem_pkg::addr_w-1:0] mem_req_addr;
    logic [mem_pkg::line_w-1:0] mem_req_wdata;
    logic                       mem_req_credit;
    logic                       mem_resp_valid;
    logic [mem_pkg::line_w-1:0] mem_resp_data;
    logic                       mem_fault;
    logic                       mem_idle;
    int                         read_cnt;
    int                         write_cnt;

    // words written by the data side
    logic [31:0] shadow [logic [31:0]];

    mem_subsys u_dut (
        .clk            (clk),
        .rst            (rst),
        .inst_addr      (inst_addr),
        .inst_read      (inst_read),
        .inst_rdata     (inst_rdata),
        .inst_ready     (inst_ready),
        .data_addr      (data_addr),
        .data_read      (data_read),
        .data_write     (data_write),
        .data_wdata     (data_wdata),
        .data_rdata     (data_rdata),
        .data_ready     (data_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req_write  (mem_req_write),
        .mem_req_addr   (mem_req_addr),
        .mem_req_wdata  (mem_req_wdata),
        .mem_req_credit (mem_req_credit),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data)
    );

    offchip_mem_model #(.fill_key(fill_key)) u_mem (
        .clk            (clk),
        .rst            (rst),
        .mem_req_valid  (mem_req_valid),
        .mem_req_write  (mem_req_write),
        .mem_req_addr   (mem_req_addr),
        .mem_req_wdata  (mem_req_wdata),
        .mem_req_credit (mem_req_credit),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data),
        .fault          (mem_fault),
        .idle           (mem_idle),
        .read_cnt       (read_cnt),
        .write_cnt      (write_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [mem_pkg::word_w-1:0] got,
                              input logic [mem_pkg::word_w-1:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s is %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR: %s is %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // untouched words still hold the fill pattern
    function automatic logic [31:0] expected_word(logic [31:0] addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return addr ^ fill_key;
    endfunction

    task automatic run_row(input row_t r);
        logic        inst_busy;
        logic        data_busy;
        logic [31:0] inst_exp;
        logic [31:0] data_exp;
        int          traffic;
        int          wait_cnt;
        inst_busy = (r.kind == k_inst) || r.par;
        data_busy = (r.kind != k_inst);
        inst_exp  = expected_word((r.kind == k_inst) ? r.addr : r.par_addr);
        data_exp  = expected_word(r.addr);
        traffic   = read_cnt + write_cnt;
        wait_cnt  = 0;
        @(posedge clk);
        inst_read  <= inst_busy;
        inst_addr  <= (r.kind == k_inst) ? r.addr : r.par_addr;
        data_read  <= (r.kind == k_read);
        data_write <= (r.kind == k_write);
        data_addr  <= r.addr;
        data_wdata <= r.wdata;
        if (r.kind == k_write) begin
            shadow[r.addr] = r.wdata;
        end
        while (inst_busy || data_busy) begin
            @(posedge clk);
            if (inst_busy && inst_ready) begin
                check_word("inst_rdata", inst_rdata, inst_exp);
                inst_read <= 1'b0;
                inst_busy = 1'b0;
            end
            if (data_busy && data_ready) begin
                if (r.kind == k_read) begin
                    check_word("data_rdata", data_rdata, data_exp);
                end
                data_read  <= 1'b0;
                data_write <= 1'b0;
                data_busy = 1'b0;
            end
            wait_cnt++;
            if (wait_cnt > timeout_cycles) begin
                if (inst_busy) begin
                    $display("instruction fetch at %h never got inst_ready", inst_addr);
                end else begin
                    $display("data access at %h never got data_ready", r.addr);
                end
                abort_run();
            end
        end
        // a hit must not touch the off-chip port
        if (r.no_fill) begin
            check_word("offchip request count", read_cnt + write_cnt, traffic);
        end
    endtask

    always @(posedge clk) begin
        if (mem_fault) begin
            abort_run();
        end
    end

    initial begin
        int drain_cnt;
        drain_cnt = 0;
        rst        <= 1'b0;
        inst_read  <= 1'b0;
        inst_addr  <= '0;
        data_read  <= 1'b0;
        data_write <= 1'b0;
        data_addr  <= '0;
        data_wdata <= '0;
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        // quiet ports after reset
        repeat (4) begin
            @(posedge clk);
            check_bit("inst_ready", inst_ready, 1'b0);
            check_bit("data_ready", data_ready, 1'b0);
            check_bit("mem_req_valid", mem_req_valid, 1'b0);
        end
        for (int i = 0; i < n_rows; i++) begin
            run_row(rows[i[4:0]]);
        end
        // every credit back and no read left in flight
        while (!mem_idle) begin
            @(posedge clk);
            drain_cnt++;
            if (drain_cnt > timeout_cycles) begin
                $display("off-chip credits or read responses never drained after the last row");
                abort_run();
            end
        end
        if (mem_fault) begin
            abort_run();
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

/* src.f */
verilog/mem_pkg.sv
verilog/bus_pkg.sv
verilog/inst_cache.sv
verilog/data_cache.sv
verilog/refill_arbiter.sv
verilog/mem_subsys.sv
sim/offchip_mem_model.sv
sim/tb_mem_subsys.sv

/* verilog/bus_pkg.sv */
// off-chip port constants, shared by the refill arbiter and the cache request logic
package bus_pkg;

    // credit counter width and the count after reset
    localparam int                  credit_w    = 2;
    localparam logic [credit_w-1:0] req_credits = 2'd2;

    // requester ids carried in the read id queue
    localparam logic [0:0] src_inst = 1'b0;
    localparam logic [0:0] src_data = 1'b1;

    // one read per cache at most
    localparam int resp_depth = 2;

endpackage

/* verilog/data_cache.sv */
// write-back write-allocate data cache, sits between the CPU load/store port and the refill arbiter
`timescale 1ns/10ps

module data_cache (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [mem_pkg::addr_w-1:0] data_addr,
    input  logic                       data_read,
    input  logic                       data_write,
    input  logic [mem_pkg::word_w-1:0] data_wdata,
    output logic [mem_pkg::word_w-1:0] data_rdata,
    output logic                       data_ready,
    output logic                       req_valid,
    output logic                       req_write,
    output logic [mem_pkg::addr_w-1:0] req_addr,
    output logic [mem_pkg::line_w-1:0] req_wdata,
    input  logic                       req_ready,
    input  logic                       resp_valid,
    input  logic [mem_pkg::line_w-1:0] resp_data
);

    typedef enum logic [1:0] {
        s_idle,
        s_wback,
        s_fill_req,
        s_fill_wait
    } state_t;

    state_t state;

    // line storage plus per-line status
    logic [mem_pkg::tag_w-1:0]             tag_arr  [1 << mem_pkg::index_bits];
    logic [mem_pkg::line_w-1:0]            data_arr [1 << mem_pkg::index_bits];
    logic [(1 << mem_pkg::index_bits)-1:0] valid_bits;
    logic [(1 << mem_pkg::index_bits)-1:0] dirty_bits;

    logic [mem_pkg::tag_w-1:0]                             addr_tag;
    logic [mem_pkg::index_bits-1:0]                        addr_idx;
    logic [mem_pkg::offset_bits-mem_pkg::word_sel_lsb-1:0] word_sel;
    logic [mem_pkg::line_w-1:0]                            cur_line;
    logic [mem_pkg::addr_w-1:0]                            line_addr;
    logic [mem_pkg::addr_w-1:0]                            victim_addr;
    logic                                                  hit;
    logic                                                  lookup;
    logic                                                  victim_dirty;

    assign addr_tag = data_addr[mem_pkg::addr_w-1 -: mem_pkg::tag_w];
    assign addr_idx = data_addr[mem_pkg::offset_bits +: mem_pkg::index_bits];
    assign word_sel = data_addr[mem_pkg::offset_bits-1:mem_pkg::word_sel_lsb];
    assign cur_line = data_arr[addr_idx];
    assign hit      = valid_bits[addr_idx] && (tag_arr[addr_idx] == addr_tag);

    assign victim_dirty = valid_bits[addr_idx] && dirty_bits[addr_idx];

    // skip the ready cycle so one access is answered once
    assign lookup = (data_read || data_write) && !data_ready && (state == s_idle);

    assign line_addr = {data_addr[mem_pkg::addr_w-1:mem_pkg::offset_bits],
                        {mem_pkg::offset_bits{1'b0}}};

    // victim goes back under its old tag
    assign victim_addr = {tag_arr[addr_idx], addr_idx, {mem_pkg::offset_bits{1'b0}}};

    // request lines follow the state, the CPU address is held for the whole miss
    assign req_valid = (state == s_wback) || (state == s_fill_req);
    assign req_write = (state == s_wback);
    assign req_addr  = (state == s_wback) ? victim_addr : line_addr;
    assign req_wdata = cur_line;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state      <= s_idle;
            data_ready <= 1'b0;
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            data_ready <= 1'b0;
            case (state)
                s_idle: begin
                    if (lookup && hit) begin
                        data_ready <= 1'b1;
                        if (data_write) begin
                            dirty_bits[addr_idx] <= 1'b1;
                        end
                    end else if (lookup && victim_dirty) begin
                        state <= s_wback;
                    end else if (lookup) begin
                        state <= s_fill_req;
                    end
                end
                s_wback: begin
                    // memory is in order, the read can follow right away
                    if (req_ready) begin
                        state <= s_fill_req;
                    end
                end
                s_fill_req: begin
                    if (req_ready) begin
                        state <= s_fill_wait;
                    end
                end
                s_fill_wait: begin
                    if (resp_valid) begin
                        valid_bits[addr_idx] <= 1'b1;
                        dirty_bits[addr_idx] <= 1'b0;
                        state                <= s_idle;
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    // refill first, the pending write then merges on the retried lookup
    always_ff @(posedge clk) begin
        if (state == s_fill_wait && resp_valid) begin
            tag_arr[addr_idx]  <= addr_tag;
            data_arr[addr_idx] <= resp_data;
        end else if (lookup && hit && data_write) begin
            data_arr[addr_idx][word_sel*mem_pkg::word_w +: mem_pkg::word_w] <= data_wdata;
        end
        if (lookup && hit && data_read) begin
            data_rdata <= cur_line[word_sel*mem_pkg::word_w +: mem_pkg::word_w];
        end
    end

    // a stalled request must hold until the arbiter takes it
    a_req_stable: assert property (@(posedge clk) disable iff (!rst)
        req_valid && !req_ready |=> req_valid && $stable(req_write)
            && $stable(req_addr) && $stable(req_wdata));

endmodule

/* verilog/inst_cache.sv */
// read-only direct-mapped instruction cache, sits between the CPU fetch port and the refill arbiter
`timescale 1ns/10ps

module inst_cache (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [mem_pkg::addr_w-1:0] inst_addr,
    input  logic                       inst_read,
    output logic [mem_pkg::word_w-1:0] inst_rdata,
    output logic                       inst_ready,
    output logic                       req_valid,
    output logic [mem_pkg::addr_w-1:0] req_addr,
    input  logic                       req_ready,
    input  logic                       resp_valid,
    input  logic [mem_pkg::line_w-1:0] resp_data
);

    typedef enum logic {
        s_idle,
        s_refill
    } state_t;

    state_t state;

    // line storage
    logic [mem_pkg::tag_w-1:0]             tag_arr  [1 << mem_pkg::index_bits];
    logic [mem_pkg::line_w-1:0]            data_arr [1 << mem_pkg::index_bits];
    logic [(1 << mem_pkg::index_bits)-1:0] valid_bits;

    logic [mem_pkg::tag_w-1:0]                             addr_tag;
    logic [mem_pkg::index_bits-1:0]                        addr_idx;
    logic [mem_pkg::offset_bits-mem_pkg::word_sel_lsb-1:0] word_sel;
    logic [mem_pkg::line_w-1:0]                            cur_line;
    logic                                                  hit;
    logic                                                  lookup;

    assign addr_tag = inst_addr[mem_pkg::addr_w-1 -: mem_pkg::tag_w];
    assign addr_idx = inst_addr[mem_pkg::offset_bits +: mem_pkg::index_bits];
    assign word_sel = inst_addr[mem_pkg::offset_bits-1:mem_pkg::word_sel_lsb];
    assign cur_line = data_arr[addr_idx];
    assign hit      = valid_bits[addr_idx] && (tag_arr[addr_idx] == addr_tag);

    // no lookup in the cycle of the ready pulse, the CPU still holds the old fetch there
    assign lookup = inst_read && !inst_ready && (state == s_idle);

    // refill always asks for the whole aligned line
    assign req_addr = {inst_addr[mem_pkg::addr_w-1:mem_pkg::offset_bits],
                       {mem_pkg::offset_bits{1'b0}}};

    always_ff @(posedge clk) begin
        if (!rst) begin
            state      <= s_idle;
            inst_ready <= 1'b0;
            req_valid  <= 1'b0;
            valid_bits <= '0;
        end else begin
            inst_ready <= 1'b0;
            case (state)
                s_idle: begin
                    if (lookup && hit) begin
                        inst_ready <= 1'b1;
                    end else if (lookup) begin
                        req_valid <= 1'b1;
                        state     <= s_refill;
                    end
                end
                s_refill: begin
                    if (req_valid && req_ready) begin
                        req_valid <= 1'b0;
                    end
                    // line lands here, the hit path answers on the next lookup
                    if (resp_valid) begin
                        valid_bits[addr_idx] <= 1'b1;
                        state                <= s_idle;
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_refill && resp_valid) begin
            tag_arr[addr_idx]  <= addr_tag;
            data_arr[addr_idx] <= resp_data;
        end
        if (lookup && hit) begin
            inst_rdata <= cur_line[word_sel*mem_pkg::word_w +: mem_pkg::word_w];
        end
    end

    // the CPU keeps inst_read up until it has sampled the ready pulse
    a_ready_needs_read: assert property (@(posedge clk) disable iff (!rst)
        inst_ready |-> inst_read);

endmodule

/* verilog/mem_pkg.sv */
// cache geometry and CPU-side widths, referenced by the caches and the subsystem top
package mem_pkg;

    // CPU side
    localparam int addr_w = 32;
    localparam int word_w = 32;

    // line geometry
    localparam int line_bytes = 16;
    localparam int line_w     = line_bytes * 8;

    // address split into tag, index and byte offset
    localparam int offset_bits = 4;
    localparam int index_bits  = 4;
    localparam int tag_w       = addr_w - index_bits - offset_bits;

    // word select sits above the byte-in-word bits
    localparam int word_sel_lsb = 2;

endpackage

/* verilog/mem_subsys.sv */
// memory subsystem top, both caches sharing one credited off-chip line port through the arbiter
`timescale 1ns/10ps

module mem_subsys (
    input  logic                       clk,
    input  logic                       rst,
    // CPU fetch port
    input  logic [mem_pkg::addr_w-1:0] inst_addr,
    input  logic                       inst_read,
    output logic [mem_pkg::word_w-1:0] inst_rdata,
    output logic                       inst_ready,
    // CPU load/store port
    input  logic [mem_pkg::addr_w-1:0] data_addr,
    input  logic                       data_read,
    input  logic                       data_write,
    input  logic [mem_pkg::word_w-1:0] data_wdata,
    output logic [mem_pkg::word_w-1:0] data_rdata,
    output logic                       data_ready,
    // off-chip line port
    output logic                       mem_req_valid,
    output logic                       mem_req_write,
    output logic [mem_pkg::addr_w-1:0] mem_req_addr,
    output logic [mem_pkg::line_w-1:0] mem_req_wdata,
    input  logic                       mem_req_credit,
    input  logic                       mem_resp_valid,
    input  logic [mem_pkg::line_w-1:0] mem_resp_data
);

    // icache to arbiter
    logic                       ic_req_valid;
    logic [mem_pkg::addr_w-1:0] ic_req_addr;
    logic                       ic_req_ready;
    logic                       ic_resp_valid;
    logic [mem_pkg::line_w-1:0] ic_resp_data;

    // dcache to arbiter
    logic                       dc_req_valid;
    logic                       dc_req_write;
    logic [mem_pkg::addr_w-1:0] dc_req_addr;
    logic [mem_pkg::line_w-1:0] dc_req_wdata;
    logic                       dc_req_ready;
    logic                       dc_resp_valid;
    logic [mem_pkg::line_w-1:0] dc_resp_data;

    inst_cache u_icache (
        .clk        (clk),
        .rst        (rst),
        .inst_addr  (inst_addr),
        .inst_read  (inst_read),
        .inst_rdata (inst_rdata),
        .inst_ready (inst_ready),
        .req_valid  (ic_req_valid),
        .req_addr   (ic_req_addr),
        .req_ready  (ic_req_ready),
        .resp_valid (ic_resp_valid),
        .resp_data  (ic_resp_data)
    );

    data_cache u_dcache (
        .clk        (clk),
        .rst        (rst),
        .data_addr  (data_addr),
        .data_read  (data_read),
        .data_write (data_write),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .data_ready (data_ready),
        .req_valid  (dc_req_valid),
        .req_write  (dc_req_write),
        .req_addr   (dc_req_addr),
        .req_wdata  (dc_req_wdata),
        .req_ready  (dc_req_ready),
        .resp_valid (dc_resp_valid),
        .resp_data  (dc_resp_data)
    );

    refill_arbiter u_arb (
        .clk             (clk),
        .rst             (rst),
        .inst_req_valid  (ic_req_valid),
        .inst_req_addr   (ic_req_addr),
        .inst_req_ready  (ic_req_ready),
        .inst_resp_valid (ic_resp_valid),
        .inst_resp_data  (ic_resp_data),
        .data_req_valid  (dc_req_valid),
        .data_req_write  (dc_req_write),
        .data_req_addr   (dc_req_addr),
        .data_req_wdata  (dc_req_wdata),
        .data_req_ready  (dc_req_ready),
        .data_resp_valid (dc_resp_valid),
        .data_resp_data  (dc_resp_data),
        .mem_req_valid   (mem_req_valid),
        .mem_req_write   (mem_req_write),
        .mem_req_addr    (mem_req_addr),
        .mem_req_wdata   (mem_req_wdata),
        .mem_req_credit  (mem_req_credit),
        .mem_resp_valid  (mem_resp_valid),
        .mem_resp_data   (mem_resp_data)
    );

endmodule

/* verilog/refill_arbiter.sv */
// round-robin arbiter putting both cache refill requests onto the credited off-chip port
`timescale 1ns/10ps

module refill_arbiter (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       inst_req_valid,
    input  logic [mem_pkg::addr_w-1:0] inst_req_addr,
    output logic                       inst_req_ready,
    output logic                       inst_resp_valid,
    output logic [mem_pkg::line_w-1:0] inst_resp_data,
    input  logic                       data_req_valid,
    input  logic                       data_req_write,
    input  logic [mem_pkg::addr_w-1:0] data_req_addr,
    input  logic [mem_pkg::line_w-1:0] data_req_wdata,
    output logic                       data_req_ready,
    output logic                       data_resp_valid,
    output logic [mem_pkg::line_w-1:0] data_resp_data,
    output logic                       mem_req_valid,
    output logic                       mem_req_write,
    output logic [mem_pkg::addr_w-1:0] mem_req_addr,
    output logic [mem_pkg::line_w-1:0] mem_req_wdata,
    input  logic                       mem_req_credit,
    input  logic                       mem_resp_valid,
    input  logic [mem_pkg::line_w-1:0] mem_resp_data
);

    logic [bus_pkg::credit_w-1:0] credit_cnt;
    logic [0:0]                   last_grant;

    // ids of reads in flight, oldest at rd_ptr
    logic [0:0]                                  id_q [bus_pkg::resp_depth];
    logic [$clog2(bus_pkg::resp_depth)-1:0]      wr_ptr;
    logic [$clog2(bus_pkg::resp_depth)-1:0]      rd_ptr;
    logic [$clog2(bus_pkg::resp_depth+1)-1:0]    q_cnt;

    logic       pick_data;
    logic       push_read;
    logic [0:0] push_id;
    logic [0:0] head_id;

    // data wins a tie only when inst had the last grant
    assign pick_data = data_req_valid && (!inst_req_valid || last_grant == bus_pkg::src_inst);

    assign inst_req_ready = (credit_cnt != '0) && inst_req_valid && !pick_data;
    assign data_req_ready = (credit_cnt != '0) && pick_data;

    assign mem_req_valid = inst_req_ready || data_req_ready;
    assign mem_req_write = data_req_ready && data_req_write;
    assign mem_req_addr  = data_req_ready ? data_req_addr : inst_req_addr;
    assign mem_req_wdata = data_req_wdata;

    assign push_read = mem_req_valid && !mem_req_write;
    assign push_id   = data_req_ready ? bus_pkg::src_data : bus_pkg::src_inst;
    assign head_id   = id_q[rd_ptr];

    // responses return in order, so the queue head names the owner
    assign inst_resp_valid = mem_resp_valid && (head_id == bus_pkg::src_inst);
    assign data_resp_valid = mem_resp_valid && (head_id == bus_pkg::src_data);
    assign inst_resp_data  = mem_resp_data;
    assign data_resp_data  = mem_resp_data;

    always_ff @(posedge clk) begin
        if (!rst) begin
            credit_cnt <= bus_pkg::req_credits;
            last_grant <= bus_pkg::src_data;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            q_cnt      <= '0;
        end else begin
            case ({mem_req_credit, mem_req_valid})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
            if (mem_req_valid) begin
                last_grant <= push_id;
            end
            if (push_read) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (mem_resp_valid) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_read, mem_resp_valid})
                2'b10:   q_cnt <= q_cnt + 1'b1;
                2'b01:   q_cnt <= q_cnt - 1'b1;
                default: q_cnt <= q_cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_read) begin
            id_q[wr_ptr] <= push_id;
        end
    end

    // memory never returns more credits than were spent
    a_credit_max: assert property (@(posedge clk) disable iff (!rst)
        credit_cnt <= bus_pkg::req_credits);

    a_resp_has_owner: assert property (@(posedge clk) disable iff (!rst)
        mem_resp_valid |-> q_cnt != '0);

endmodule
